/* ninjin_wbuf.f */
src/ninjin_pkg.sv
src/word_packer.sv
src/burst_bank.sv
src/burst_drainer.sv
src/ninjin_wbuf.sv
sim/tb_clock.sv
sim/ninjin_wbuf_chk.sv
sim/ninjin_wbuf_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module ninjin_wbuf_tb -Mdir obj_dir -f ninjin_wbuf.f

out=$(./obj_dir/Vninjin_wbuf_tb || true)
echo "$out"

if grep -q "^Test passed$" <<< "$out"; then
  exit 0
else
  exit 1
fi

/* sim/ninjin_wbuf_chk.sv */
`timescale 1ns/1ns

module ninjin_wbuf_chk (
  input logic clk,
  input logic xrst,
  input logic mem_ready,
  input logic ddr_credit,
  input logic ddr_req,
  input logic ddr_we,
  input logic done
);

  int unsigned granted;
  int unsigned sent;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      granted <= 0;
      sent    <= 0;
    end else begin
      granted <= granted + ddr_credit;
      sent    <= sent + ddr_we;
    end
  end

  // ==========================================================================
  // DDR side
  // ==========================================================================

  a_req_we_apart: assert property (@(posedge clk) disable iff (!xrst) !(ddr_req && ddr_we))
    else $error("ddr_req and ddr_we high in the same cycle");

  a_beat_has_credit: assert property (@(posedge clk) disable iff (!xrst)
    ddr_we |-> sent < granted)
    else $error("beat sent without a granted credit");

  a_done_single: assert property (@(posedge clk) disable iff (!xrst) done |=> !done)
    else $error("done longer than one cycle");

  // compute side
  a_idle_at_done: assert property (@(posedge clk) disable iff (!xrst)
    done |-> !mem_ready)
    else $error("mem_ready high while done");

endmodule

/* sim/ninjin_wbuf_tb.sv */
`timescale 1ns/1ns

module ninjin_wbuf_tb;

  localparam int RATE         = ninjin_pkg::RATE;
  localparam int BURST_LEN    = ninjin_pkg::BURST_LEN;
  localparam int DDR_CREDITS  = 4;
  localparam int NROWS        = 5;
  localparam int PERIOD       = 40;
  localparam int CYC_PER_WORD = 16;

  localparam logic [1:0] STEADY = 2'd0;
  localparam logic [1:0] RANDOM = 2'd1;
  localparam logic [1:0] STARVE = 2'd2;

  typedef struct packed {
    ninjin_pkg::addr_t base;
    ninjin_pkg::len_t  len;
    logic [1:0]        mode;
  } row_t;

  // starved row first so the DUT holds no leftover DDR credits
  row_t rows [NROWS] = '{
    '{16'h0040, 12'd100, STARVE},
    '{16'h0100, 12'd96,  STEADY},
    '{16'h2000, 12'd37,  STEADY},
    '{16'h7ff0, 12'd61,  RANDOM},
    '{16'hc004, 12'd5,   RANDOM}
  };

  logic               clk;
  logic               xrst;
  logic               start;
  ninjin_pkg::addr_t  base_addr;
  ninjin_pkg::len_t   total_len;
  logic               mem_we;
  ninjin_pkg::word_t  mem_wdata;
  logic               mem_ready;
  logic               ddr_credit;
  logic               ddr_req;
  ninjin_pkg::burst_t ddr_burst;
  logic               ddr_we;
  ninjin_pkg::beat_t  ddr_wdata;
  logic               done;

  int                 seed = 32'h16fb;
  ninjin_pkg::word_t  word_q [$];
  ninjin_pkg::burst_t hdr_q [$];
  int                 xfer_left = 0;
  int                 burst_left = 0;
  int                 granted = 0;
  int                 beats = 0;
  int                 done_cnt = 0;
  int                 words_fed = 0;

  tb_clock #(.HALF(PERIOD / 2), .RST_CYCLES(8)) u_clk (.clk(clk), .xrst(xrst));

  ninjin_wbuf #(
    .RATE        (RATE),
    .BURST_LEN   (BURST_LEN),
    .NUM_BANKS   (2),
    .DDR_CREDITS (DDR_CREDITS)
  ) u_dut (
    .clk        (clk),
    .xrst       (xrst),
    .start      (start),
    .base_addr  (base_addr),
    .total_len  (total_len),
    .mem_we     (mem_we),
    .mem_wdata  (mem_wdata),
    .mem_ready  (mem_ready),
    .ddr_credit (ddr_credit),
    .ddr_req    (ddr_req),
    .ddr_burst  (ddr_burst),
    .ddr_we     (ddr_we),
    .ddr_wdata  (ddr_wdata),
    .done       (done)
  );

  bind ninjin_wbuf ninjin_wbuf_chk u_chk (
    .clk        (clk),
    .xrst       (xrst),
    .mem_ready  (mem_ready),
    .ddr_credit (ddr_credit),
    .ddr_req    (ddr_req),
    .ddr_we     (ddr_we),
    .done       (done)
  );

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      fail_run("value mismatch");
    end
  endtask

  // ==========================================================================
  // reference model
  // ==========================================================================

  task automatic build_headers(input ninjin_pkg::addr_t base, input int len);
    ninjin_pkg::burst_t h;
    int                 words;
    int                 n;
    words = len;
    while (words > 0) begin
      n = (words + RATE - 1) / RATE;
      if (n > BURST_LEN) begin
        n = BURST_LEN;
      end
      words -= n * RATE;
      h.base = base;
      h.len  = ninjin_pkg::len_t'(n);
      h.last = words <= 0;
      hdr_q.push_back(h);
      base = ninjin_pkg::addr_t'(base + RATE * BURST_LEN);
    end
  endtask

  // first word in lane 0 and lanes past the transfer end are zero
  always @(negedge clk) begin
    ninjin_pkg::beat_t  exp;
    ninjin_pkg::burst_t hdr;
    if (xrst) begin
      if (ddr_req) begin
        if (hdr_q.size() == 0) begin
          fail_run("burst header seen with no burst expected");
        end
        hdr = hdr_q.pop_front();
        check_eq("beats before ddr_req", burst_left, 0);
        check_eq("ddr_burst", ddr_burst, hdr);
        burst_left = hdr.len;
      end
      if (ddr_we) begin
        if (burst_left == 0) begin
          fail_run("beat seen outside a burst");
        end
        exp = '0;
        for (int l = 0; l < RATE; l++) begin
          if (xfer_left > 0) begin
            if (word_q.size() == 0) begin
              fail_run("beat seen before its words were written");
            end
            exp[l*ninjin_pkg::DWIDTH +: ninjin_pkg::DWIDTH] = word_q.pop_front();
            xfer_left--;
          end
        end
        check_eq("ddr_wdata", ddr_wdata, exp);
        burst_left--;
        beats++;
      end
      if (done) begin
        check_eq("words pending at done", xfer_left, 0);
        done_cnt++;
      end
    end
  end

  // ==========================================================================
  // stimulus
  // ==========================================================================

  task automatic pulse_start(input ninjin_pkg::addr_t base, input ninjin_pkg::len_t len);
    @(negedge clk);
    start     = 1'b1;
    base_addr = base;
    total_len = len;
    @(negedge clk);
    start = 1'b0;
  endtask

  task automatic feed_words(input int n);
    int sent;
    sent      = 0;
    words_fed = 0;
    base_addr = 16'hbad0;
    total_len = 12'd3;
    while (sent < n) begin
      mem_we = 1'b0;
      // second start halfway through the busy transfer
      start = (sent == n / 2);
      if (mem_ready && ($random(seed) & 3) != 0) begin
        mem_we    = 1'b1;
        mem_wdata = ninjin_pkg::word_t'($random(seed));
        word_q.push_back(mem_wdata);
        sent++;
        words_fed = sent;
      end
      @(negedge clk);
    end
    mem_we = 1'b0;
    start  = 1'b0;
  endtask

  task automatic drive_credits(input logic [1:0] mode, input int done0);
    int beats0;
    beats0 = beats;
    if (mode == STARVE) begin
      // both banks closed and nothing granted
      while (words_fed < 2 * RATE * BURST_LEN) @(negedge clk);
      repeat (2) @(negedge clk);
      check_eq("mem_ready", mem_ready, 0);
      check_eq("beats while starved", beats - beats0, 0);
    end
    while (done_cnt == done0) begin
      @(negedge clk);
      ddr_credit = 1'b0;
      if (granted - beats < DDR_CREDITS) begin
        if (mode == STEADY) begin
          ddr_credit = 1'b1;
        end else if (($random(seed) & 31) == 0) begin
          repeat (40) @(negedge clk);
        end else begin
          ddr_credit = $random(seed) & 1;
        end
        granted += ddr_credit;
      end
    end
    ddr_credit = 1'b0;
  endtask

  task automatic run_row(input row_t row);
    int done0;
    done0     = done_cnt;
    xfer_left = row.len;
    build_headers(row.base, row.len);
    fork
      begin
        pulse_start(row.base, row.len);
        feed_words(row.len);
      end
      drive_credits(row.mode, done0);
    join
    repeat (4) @(negedge clk);
    check_eq("done pulses", done_cnt - done0, 1);
    check_eq("mem_ready after done", mem_ready, 0);
    check_eq("headers left", hdr_q.size(), 0);
    check_eq("beats left in burst", burst_left, 0);
  endtask

  initial begin
    start      = 1'b0;
    base_addr  = '0;
    total_len  = '0;
    mem_we     = 1'b0;
    mem_wdata  = '0;
    ddr_credit = 1'b0;
    @(posedge xrst);
    @(negedge clk);
    check_eq("mem_ready", mem_ready, 0);
    check_eq("ddr_req", ddr_req, 0);
    check_eq("ddr_we", ddr_we, 0);
    check_eq("done", done, 0);
    for (int r = 0; r < NROWS; r++) begin
      run_row(rows[r]);
    end
    $display("Test passed");
    $finish;
  end

  // limit grows with the total word count of the table
  initial begin
    longint limit;
    limit = 64;
    for (int r = 0; r < NROWS; r++) begin
      limit += longint'(rows[r].len) * CYC_PER_WORD;
    end
    #(limit * PERIOD);
    fail_run($sformatf("timeout, transfers not finished after %0d cycles", limit));
  end

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock #(
  parameter int HALF       = 20,
  parameter int RST_CYCLES = 8
) (
  output logic clk,
  output logic xrst
);

  initial begin
    clk = 1'b0;
    forever #HALF clk = ~clk;
  end

  // release on a falling edge, away from the sampling edge
  initial begin
    xrst = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    xrst = 1'b1;
  end

endmodule

/* src/burst_bank.sv */
`timescale 1ns/1ns

module burst_bank #(
  parameter int BURST_LEN = 8,
  parameter int IDX_W     = 3
) (
  input  logic                    clk,
  input  logic                    xrst,
  input  logic                    sel,
  input  ninjin_pkg::bank_wr_t    bank_wr,
  input  ninjin_pkg::bank_close_t bank_close,
  input  ninjin_pkg::len_t        rd_idx,
  input  logic                    bank_rel,
  output logic                    full,
  output ninjin_pkg::burst_t      burst,
  output ninjin_pkg::beat_t       rd_data
);

  ninjin_pkg::beat_t mem [BURST_LEN];

  logic take_wr;
  logic take_close;

  assign take_wr    = sel && bank_wr.we;
  assign take_close = sel && bank_close.close;

  // ==========================================================================
  // storage
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (take_wr) begin
      mem[bank_wr.idx[IDX_W-1:0]] <= bank_wr.beat;
    end
    // read port registered, beat follows its index by one cycle
    rd_data <= mem[rd_idx[IDX_W-1:0]];
  end

  always_ff @(posedge clk) begin
    if (take_close) begin
      burst <= bank_close.burst;
    end
  end

  // owned by the drainer while full
  always_ff @(posedge clk) begin
    if (!xrst) begin
      full <= 1'b0;
    end else if (take_close) begin
      full <= 1'b1;
    end else if (bank_rel) begin
      full <= 1'b0;
    end
  end

endmodule

/* src/burst_drainer.sv */
`timescale 1ns/1ns

module burst_drainer #(
  parameter int NUM_BANKS   = 2,
  parameter int DDR_CREDITS = 4
) (
  input  logic                     clk,
  input  logic                     xrst,
  input  logic                     start,
  input  logic [NUM_BANKS-1:0]     full,
  input  ninjin_pkg::burst_t       burst [NUM_BANKS],
  input  ninjin_pkg::beat_t        rd_data [NUM_BANKS],
  input  logic                     ddr_credit,
  output ninjin_pkg::len_t         rd_idx,
  output logic [NUM_BANKS-1:0]     bank_rel,
  output logic [NUM_BANKS-1:0]     bank_credit,
  output logic                     ddr_req,
  output ninjin_pkg::burst_t       ddr_burst,
  output logic                     ddr_we,
  output ninjin_pkg::beat_t        ddr_wdata,
  output logic                     done
);

  localparam int CNT_W = $clog2(DDR_CREDITS + 1);

  ninjin_pkg::drain_state_t state;
  logic                     busy;
  ninjin_pkg::bank_idx_t    ptr;
  ninjin_pkg::burst_t       hdr;
  ninjin_pkg::len_t         issued;
  logic                     we_q;
  logic [CNT_W-1:0]         ccnt;
  logic                     done_q;
  logic                     issue;
  logic                     final_rel;

  // one beat read per available DDR credit
  assign issue     = state == ninjin_pkg::D_BEATS && issued != hdr.len && ccnt != '0;
  assign final_rel = state == ninjin_pkg::D_RELEASE && hdr.last;

  // ==========================================================================
  // drain FSM
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state  <= ninjin_pkg::D_IDLE;
      busy   <= 1'b0;
      ptr    <= '0;
      issued <= '0;
      we_q   <= 1'b0;
      ccnt   <= '0;
      done_q <= 1'b0;
    end else begin
      we_q   <= issue;
      done_q <= final_rel;
      ccnt   <= ccnt - CNT_W'(issue) + CNT_W'(ddr_credit);
      case (state)
        ninjin_pkg::D_IDLE: begin
          if (busy && full[ptr]) begin
            state <= ninjin_pkg::D_HEAD;
          end
        end
        ninjin_pkg::D_HEAD: begin
          issued <= '0;
          state  <= ninjin_pkg::D_BEATS;
        end
        ninjin_pkg::D_BEATS: begin
          if (issue) begin
            issued <= issued + 1'b1;
          end
          // last beat is on the bus in this cycle
          if (issued == hdr.len) begin
            state <= ninjin_pkg::D_RELEASE;
          end
        end
        ninjin_pkg::D_RELEASE: begin
          state <= ninjin_pkg::D_IDLE;
          if (ptr == ninjin_pkg::bank_idx_t'(NUM_BANKS - 1)) begin
            ptr <= '0;
          end else begin
            ptr <= ptr + 1'b1;
          end
        end
        default: begin
          state <= ninjin_pkg::D_IDLE;
        end
      endcase
      if (start && !busy) begin
        busy <= 1'b1;
        ptr  <= '0;
      end else if (final_rel) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == ninjin_pkg::D_IDLE && full[ptr]) begin
      hdr <= burst[ptr];
    end
  end

  // ==========================================================================
  // outputs
  // ==========================================================================

  assign rd_idx      = issued;
  assign ddr_req     = state == ninjin_pkg::D_HEAD;
  assign ddr_burst   = hdr;
  assign ddr_we      = we_q;
  assign ddr_wdata   = rd_data[ptr];
  assign done        = done_q;
  assign bank_rel    = (state == ninjin_pkg::D_RELEASE) ? NUM_BANKS'(1) << ptr : '0;
  assign bank_credit = bank_rel;

endmodule

/* src/ninjin_pkg.sv */
package ninjin_pkg;

  // ==========================================================================
  // geometry
  // ==========================================================================

  localparam int DWIDTH    = 16;
  localparam int RATE      = 4;
  localparam int RATELOG   = 2;
  localparam int BWIDTH    = DWIDTH << RATELOG;
  localparam int BURST_LEN = 8;
  localparam int IMGSIZE   = 16;
  localparam int LWIDTH    = 12;

  typedef logic signed [DWIDTH-1:0] word_t;
  typedef logic [BWIDTH-1:0]        beat_t;
  typedef logic [IMGSIZE-1:0]       addr_t;
  typedef logic [LWIDTH-1:0]        len_t;
  typedef logic                     bank_idx_t;

  // ==========================================================================
  // bank traffic
  // ==========================================================================

  typedef struct packed {
    logic  we;
    len_t  idx;
    beat_t beat;
  } bank_wr_t;

  // len counts beats, not words
  typedef struct packed {
    addr_t base;
    len_t  len;
    logic  last;
  } burst_t;

  typedef struct packed {
    logic   close;
    burst_t burst;
  } bank_close_t;

  typedef enum logic [1:0] {
    D_IDLE    = 2'd0,
    D_HEAD    = 2'd1,
    D_BEATS   = 2'd2,
    D_RELEASE = 2'd3
  } drain_state_t;

endpackage

/* src/ninjin_wbuf.sv */
`timescale 1ns/1ns

module ninjin_wbuf #(
  parameter int RATE        = ninjin_pkg::RATE,
  parameter int BURST_LEN   = ninjin_pkg::BURST_LEN,
  parameter int NUM_BANKS   = 2,
  parameter int DDR_CREDITS = 4
) (
  input  logic               clk,
  input  logic               xrst,
  input  logic               start,
  input  ninjin_pkg::addr_t  base_addr,
  input  ninjin_pkg::len_t   total_len,
  input  logic               mem_we,
  input  ninjin_pkg::word_t  mem_wdata,
  output logic               mem_ready,
  input  logic               ddr_credit,
  output logic               ddr_req,
  output ninjin_pkg::burst_t ddr_burst,
  output logic               ddr_we,
  output ninjin_pkg::beat_t  ddr_wdata,
  output logic               done
);

  // lane counter and bank address widths
  localparam int LANE_W = (RATE > 1) ? $clog2(RATE) : 1;
  localparam int IDX_W  = (BURST_LEN > 1) ? $clog2(BURST_LEN) : 1;

  ninjin_pkg::bank_wr_t    bank_wr;
  ninjin_pkg::bank_close_t bank_close;
  logic [NUM_BANKS-1:0]    bank_sel;
  logic [NUM_BANKS-1:0]    bank_credit;
  logic [NUM_BANKS-1:0]    bank_rel;
  logic [NUM_BANKS-1:0]    bank_full;
  ninjin_pkg::burst_t      bank_burst [NUM_BANKS];
  ninjin_pkg::beat_t       bank_rd [NUM_BANKS];
  ninjin_pkg::len_t        rd_idx;

  word_packer #(
    .RATE      (RATE),
    .BURST_LEN (BURST_LEN),
    .NUM_BANKS (NUM_BANKS),
    .LANE_W    (LANE_W)
  ) u_packer (
    .clk         (clk),
    .xrst        (xrst),
    .start       (start),
    .base_addr   (base_addr),
    .total_len   (total_len),
    .mem_we      (mem_we),
    .mem_wdata   (mem_wdata),
    .bank_credit (bank_credit),
    .mem_ready   (mem_ready),
    .bank_wr     (bank_wr),
    .bank_close  (bank_close),
    .bank_sel    (bank_sel)
  );

  // ping-pong banks, one fills while the other drains
  for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
    burst_bank #(
      .BURST_LEN (BURST_LEN),
      .IDX_W     (IDX_W)
    ) u_bank (
      .clk        (clk),
      .xrst       (xrst),
      .sel        (bank_sel[i]),
      .bank_wr    (bank_wr),
      .bank_close (bank_close),
      .rd_idx     (rd_idx),
      .bank_rel   (bank_rel[i]),
      .full       (bank_full[i]),
      .burst      (bank_burst[i]),
      .rd_data    (bank_rd[i])
    );
  end

  burst_drainer #(
    .NUM_BANKS   (NUM_BANKS),
    .DDR_CREDITS (DDR_CREDITS)
  ) u_drainer (
    .clk         (clk),
    .xrst        (xrst),
    .start       (start),
    .full        (bank_full),
    .burst       (bank_burst),
    .rd_data     (bank_rd),
    .ddr_credit  (ddr_credit),
    .rd_idx      (rd_idx),
    .bank_rel    (bank_rel),
    .bank_credit (bank_credit),
    .ddr_req     (ddr_req),
    .ddr_burst   (ddr_burst),
    .ddr_we      (ddr_we),
    .ddr_wdata   (ddr_wdata),
    .done        (done)
  );

endmodule

/* src/word_packer.sv */
`timescale 1ns/1ns

module word_packer #(
  parameter int RATE      = 4,
  parameter int BURST_LEN = 8,
  parameter int NUM_BANKS = 2,
  parameter int LANE_W    = 2
) (
  input  logic                    clk,
  input  logic                    xrst,
  input  logic                    start,
  input  ninjin_pkg::addr_t       base_addr,
  input  ninjin_pkg::len_t        total_len,
  input  logic                    mem_we,
  input  ninjin_pkg::word_t       mem_wdata,
  input  logic [NUM_BANKS-1:0]    bank_credit,
  output logic                    mem_ready,
  output ninjin_pkg::bank_wr_t    bank_wr,
  output ninjin_pkg::bank_close_t bank_close,
  output logic [NUM_BANKS-1:0]    bank_sel
);

  localparam int CRED_W = $clog2(NUM_BANKS + 1);

  logic                  busy;
  ninjin_pkg::len_t      words_left;
  logic [LANE_W-1:0]     lane;
  ninjin_pkg::len_t      beat_cnt;
  ninjin_pkg::bank_idx_t ptr;
  logic [CRED_W-1:0]     credits;
  logic [CRED_W-1:0]     credits_next;
  ninjin_pkg::addr_t     burst_base;
  ninjin_pkg::beat_t     beat_reg;
  ninjin_pkg::beat_t     beat_next;
  logic                  wr_we_q;
  ninjin_pkg::len_t      wr_idx_q;
  logic                  close_q;
  ninjin_pkg::burst_t    hdr_q;
  logic                  take_start;
  logic                  accept;
  logic                  last_word;
  logic                  beat_done;
  logic                  close_now;

  // ==========================================================================
  // acceptance and credits
  // ==========================================================================

  assign take_start = start && !busy;
  assign mem_ready  = busy && words_left != '0 && credits != '0;
  assign accept     = mem_we && mem_ready;
  assign last_word  = words_left == ninjin_pkg::len_t'(1);
  assign beat_done  = lane == LANE_W'(RATE - 1) || last_word;

  // bank ends on a full burst or on the final word
  assign close_now = accept && beat_done
                  && (beat_cnt == ninjin_pkg::len_t'(BURST_LEN - 1) || last_word);

  assign credits_next = credits - CRED_W'(close_now) + CRED_W'(|bank_credit);

  // first word lands in lane 0, lanes above the last word stay zero
  always_comb begin
    beat_next = (lane == '0) ? '0 : beat_reg;
    beat_next[lane*ninjin_pkg::DWIDTH +: ninjin_pkg::DWIDTH] = mem_wdata;
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      busy       <= 1'b0;
      words_left <= '0;
      lane       <= '0;
      beat_cnt   <= '0;
      credits    <= '0;
      ptr        <= '0;
      wr_we_q    <= 1'b0;
      close_q    <= 1'b0;
    end else begin
      wr_we_q <= accept && beat_done;
      close_q <= close_now;
      if (take_start) begin
        busy       <= 1'b1;
        words_left <= total_len;
        lane       <= '0;
        beat_cnt   <= '0;
        credits    <= CRED_W'(NUM_BANKS);
        ptr        <= '0;
      end else begin
        // transfer ends once every bank has come back
        if (busy && words_left == '0 && credits_next == CRED_W'(NUM_BANKS)) begin
          busy <= 1'b0;
        end
        credits <= credits_next;
        if (accept) begin
          words_left <= words_left - 1'b1;
          lane       <= beat_done ? '0 : lane + 1'b1;
          if (close_now) begin
            beat_cnt <= '0;
          end else if (beat_done) begin
            beat_cnt <= beat_cnt + 1'b1;
          end
        end
        // select follows the close by one cycle
        if (close_q) begin
          if (ptr == ninjin_pkg::bank_idx_t'(NUM_BANKS - 1)) begin
            ptr <= '0;
          end else begin
            ptr <= ptr + 1'b1;
          end
        end
      end
    end
  end

  // ==========================================================================
  // beat and header registers
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (take_start) begin
      burst_base <= base_addr;
    end else if (close_now) begin
      burst_base <= burst_base + ninjin_pkg::addr_t'(RATE * BURST_LEN);
    end
    if (accept) begin
      beat_reg <= beat_next;
      if (beat_done) begin
        wr_idx_q <= beat_cnt;
      end
      if (close_now) begin
        hdr_q.base <= burst_base;
        hdr_q.len  <= beat_cnt + 1'b1;
        hdr_q.last <= last_word;
      end
    end
  end

  assign bank_wr    = '{we: wr_we_q, idx: wr_idx_q, beat: beat_reg};
  assign bank_close = '{close: close_q, burst: hdr_q};
  assign bank_sel   = NUM_BANKS'(1) << ptr;

endmodule
